// ==== rtl/cnn_dims_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// LeNet layer 1 sizes: 28x28 image, two 5x5 kernels, 2x2 max-pool.
// Address widths are derived from these sizes and must not be narrowed.
//////////////////////////////////////////////////////////////////////
`default_nettype none

package cnn_dims_pkg;

    // input image
    localparam int IMG_W      = 28;
    localparam int IMG_PIXELS = IMG_W * IMG_W;

    // convolution 1 kernels
    localparam int K_W    = 5;
    localparam int K_TAPS = K_W * K_W;
    localparam int NUM_K  = 2;

    // valid convolution, no padding
    localparam int CONV_W      = IMG_W - K_W + 1;
    localparam int CONV_PIXELS = CONV_W * CONV_W;

    // 2x2 pooling, stride 2
    localparam int POOL_W      = CONV_W / 2;
    localparam int POOL_PIXELS = POOL_W * POOL_W;

    localparam int IMG_AW  = $clog2(IMG_PIXELS);
    localparam int K_AW    = $clog2(NUM_K * K_TAPS);
    localparam int FMAP_AW = $clog2(NUM_K * CONV_PIXELS);
    localparam int POOL_AW = $clog2(NUM_K * POOL_PIXELS);

    // image memory, row-major
    typedef logic [IMG_AW-1:0] img_addr_t;
    // kernel k starts at k * K_TAPS
    typedef logic [K_AW-1:0] k_addr_t;
    // channel k map starts at k * CONV_PIXELS
    typedef logic [FMAP_AW-1:0] fmap_addr_t;
    // channel k pooled map starts at k * POOL_PIXELS
    typedef logic [POOL_AW-1:0] pool_addr_t;

endpackage

`default_nettype wire

// ==== rtl/cnn_ctrl_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Layer phases of the address controller, one pass per start.
//////////////////////////////////////////////////////////////////////
`default_nettype none

package cnn_ctrl_pkg;

    // one phase per layer step, DONE holds until the next start
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        CONV,
        POOL,
        DONE
    } phase_t;

endpackage

`default_nettype wire

// ==== rtl/addr_stream_if.sv ====
//////////////////////////////////////////////////////////////////////
// Convolution address stream, valid/ready, held item until transfer.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

interface addr_stream_if
    import cnn_dims_pkg::*;
();

    logic       valid;
    logic       ready;
    img_addr_t  img_addr;
    k_addr_t    k_addr;
    fmap_addr_t out_addr;
    // marks the 25th tap of an output pixel
    logic       last_tap;

    modport source (
        output valid, img_addr, k_addr, out_addr, last_tap,
        input  ready
    );

    modport sink (
        input  valid, img_addr, k_addr, out_addr, last_tap,
        output ready
    );

endinterface

`default_nettype wire

// ==== rtl/conv_window_addr.sv ====
//////////////////////////////////////////////////////////////////////
// Walks conv 1 as kernel, row, col, tap. No multipliers, running bases.
// go restarts the walk at once, so issue it only when idle.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module conv_window_addr
    import cnn_dims_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          go,
    output logic          finished,
    addr_stream_if.source stream
);

    logic       kern;
    logic [4:0] row, col;
    logic [2:0] kr, kc;
    logic       valid;

    // row_base = row*28, win_base = row_base + col, tap_base = win_base + kr*28
    img_addr_t  row_base, win_base, tap_base, img_addr, next_win;
    k_addr_t    k_base, k_addr;
    fmap_addr_t out_addr;

    logic kc_end, kr_end, col_end, row_end, tap_end, last_item, xfer;

    assign kc_end    = (kc == 3'(K_W - 1));
    assign kr_end    = (kr == 3'(K_W - 1));
    assign col_end   = (col == 5'(CONV_W - 1));
    assign row_end   = (row == 5'(CONV_W - 1));
    assign tap_end   = kc_end && kr_end;
    assign last_item = tap_end && col_end && row_end && (kern == 1'(NUM_K - 1));
    assign xfer      = valid && stream.ready;
    assign finished  = xfer && last_item;

    // top-left corner of the next output window
    always_comb begin
        if (!col_end)
            next_win = win_base + 1'b1;
        else if (!row_end)
            next_win = row_base + img_addr_t'(IMG_W);
        else
            next_win = '0;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid    <= 1'b0;
            kern     <= 1'b0;
            row      <= '0;
            col      <= '0;
            kr       <= '0;
            kc       <= '0;
            row_base <= '0;
            win_base <= '0;
            tap_base <= '0;
            img_addr <= '0;
            k_base   <= '0;
            k_addr   <= '0;
            out_addr <= '0;
        end else if (go) begin
            valid    <= 1'b1;
            kern     <= 1'b0;
            row      <= '0;
            col      <= '0;
            kr       <= '0;
            kc       <= '0;
            row_base <= '0;
            win_base <= '0;
            tap_base <= '0;
            img_addr <= '0;
            k_base   <= '0;
            k_addr   <= '0;
            out_addr <= '0;
        end else if (xfer) begin
            if (last_item) begin
                valid <= 1'b0;
            end else if (!kc_end) begin
                kc       <= kc + 1'b1;
                img_addr <= img_addr + 1'b1;
                k_addr   <= k_addr + 1'b1;
            end else if (!kr_end) begin
                // next kernel row, one image row down
                kc       <= '0;
                kr       <= kr + 1'b1;
                tap_base <= tap_base + img_addr_t'(IMG_W);
                img_addr <= tap_base + img_addr_t'(IMG_W);
                k_addr   <= k_addr + 1'b1;
            end else begin
                // output pixel complete
                kc       <= '0;
                kr       <= '0;
                out_addr <= out_addr + 1'b1;
                win_base <= next_win;
                tap_base <= next_win;
                img_addr <= next_win;
                if (!col_end) begin
                    col    <= col + 1'b1;
                    k_addr <= k_base;
                end else begin
                    col <= '0;
                    if (!row_end) begin
                        row      <= row + 1'b1;
                        row_base <= row_base + img_addr_t'(IMG_W);
                        k_addr   <= k_base;
                    end else begin
                        // move on to the next kernel
                        row      <= '0;
                        row_base <= '0;
                        kern     <= kern + 1'b1;
                        k_base   <= k_base + k_addr_t'(K_TAPS);
                        k_addr   <= k_base + k_addr_t'(K_TAPS);
                    end
                end
            end
        end
    end

    assign stream.valid    = valid;
    assign stream.img_addr = img_addr;
    assign stream.k_addr   = k_addr;
    assign stream.out_addr = out_addr;
    assign stream.last_tap = tap_end;

    a_img_in_range: assert property (@(posedge clk) disable iff (reset)
        valid |-> (img_addr < img_addr_t'(IMG_PIXELS)));

    a_hold_item: assert property (@(posedge clk) disable iff (reset)
        (valid && !stream.ready) |=> (valid && $stable(img_addr) && $stable(k_addr)
            && $stable(out_addr) && $stable(tap_end)));

endmodule

`default_nettype wire

// ==== rtl/pool_window_addr.sv ====
//////////////////////////////////////////////////////////////////////
// Walks pooling 1 as channel, pooled row, pooled col; 2x2 stride 2.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module pool_window_addr
    import cnn_dims_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       go,
    output logic       finished,
    output logic       valid,
    input  logic       ready,
    output fmap_addr_t rd_addr [4],
    output pool_addr_t wr_addr
);

    logic       ch;
    logic [3:0] pr, pc;
    // top-left of the 2x2 window in the conv map
    fmap_addr_t base;
    logic       pc_end, last_item, xfer;

    assign pc_end    = (pc == 4'(POOL_W - 1));
    assign last_item = pc_end && (pr == 4'(POOL_W - 1)) && (ch == 1'(NUM_K - 1));
    assign xfer      = valid && ready;
    assign finished  = xfer && last_item;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid   <= 1'b0;
            ch      <= 1'b0;
            pr      <= '0;
            pc      <= '0;
            base    <= '0;
            wr_addr <= '0;
        end else if (go) begin
            valid   <= 1'b1;
            ch      <= 1'b0;
            pr      <= '0;
            pc      <= '0;
            base    <= '0;
            wr_addr <= '0;
        end else if (xfer) begin
            if (last_item) begin
                valid <= 1'b0;
            end else begin
                // pooled map is row-major across channels
                wr_addr <= wr_addr + 1'b1;
                if (!pc_end) begin
                    pc   <= pc + 1'b1;
                    base <= base + fmap_addr_t'(2);
                end else begin
                    // skip the second row of the pair, also lands on next channel
                    pc   <= '0;
                    base <= base + fmap_addr_t'(CONV_W + 2);
                    if (pr != 4'(POOL_W - 1)) begin
                        pr <= pr + 1'b1;
                    end else begin
                        pr <= '0;
                        ch <= ch + 1'b1;
                    end
                end
            end
        end
    end

    assign rd_addr[0] = base;
    assign rd_addr[1] = base + fmap_addr_t'(1);
    assign rd_addr[2] = base + fmap_addr_t'(CONV_W);
    assign rd_addr[3] = base + fmap_addr_t'(CONV_W + 1);

    a_hold_item: assert property (@(posedge clk) disable iff (reset)
        (valid && !ready) |=> (valid && $stable(base) && $stable(wr_addr)));

endmodule

`default_nettype wire

// ==== rtl/layer_sequencer.sv ====
//////////////////////////////////////////////////////////////////////
// Phase FSM: LOAD takes 784 pixels, then one conv and one pool walk.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module layer_sequencer
    import cnn_dims_pkg::*, cnn_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      start,
    input  logic      pix_valid,
    output logic      pix_ready,
    output img_addr_t img_wr_addr,
    output logic      conv_go,
    input  logic      conv_finished,
    output logic      pool_go,
    input  logic      pool_finished,
    output logic      done,
    output phase_t    phase
);

    phase_t state;
    logic   load_last;

    assign load_last = pix_valid && (img_wr_addr == img_addr_t'(IMG_PIXELS - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= IDLE;
            img_wr_addr <= '0;
            conv_go     <= 1'b0;
            pool_go     <= 1'b0;
        end else begin
            // go pulses last one cycle, raised on phase entry
            conv_go <= 1'b0;
            pool_go <= 1'b0;
            case (state)
                IDLE, DONE: begin
                    if (start) begin
                        state       <= LOAD;
                        img_wr_addr <= '0;
                    end
                end
                LOAD: begin
                    if (load_last) begin
                        state       <= CONV;
                        conv_go     <= 1'b1;
                        img_wr_addr <= '0;
                    end else if (pix_valid) begin
                        img_wr_addr <= img_wr_addr + 1'b1;
                    end
                end
                CONV: begin
                    if (conv_finished) begin
                        state   <= POOL;
                        pool_go <= 1'b1;
                    end
                end
                POOL: begin
                    if (pool_finished)
                        state <= DONE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign pix_ready = (state == LOAD);
    assign done      = (state == DONE);
    assign phase     = state;

    a_conv_go_in_phase: assert property (@(posedge clk) disable iff (reset)
        conv_go |-> (state == CONV));

    a_pool_go_in_phase: assert property (@(posedge clk) disable iff (reset)
        pool_go |-> (state == POOL));

endmodule

`default_nettype wire

// ==== rtl/cnn_addr_ctrl.sv ====
//////////////////////////////////////////////////////////////////////
// Address side of LeNet layer 1; addresses and flags only, no data.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module cnn_addr_ctrl
    import cnn_dims_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  logic       pix_valid,
    output logic       pix_ready,
    output img_addr_t  img_wr_addr,
    output logic       conv_valid,
    input  logic       conv_ready,
    output img_addr_t  conv_img_addr,
    output k_addr_t    conv_k_addr,
    output fmap_addr_t conv_out_addr,
    output logic       conv_last_tap,
    output logic       pool_valid,
    input  logic       pool_ready,
    output fmap_addr_t pool_rd_addr0,
    output fmap_addr_t pool_rd_addr1,
    output fmap_addr_t pool_rd_addr2,
    output fmap_addr_t pool_rd_addr3,
    output pool_addr_t pool_wr_addr,
    output logic       done
);

    logic       conv_go, conv_finished;
    logic       pool_go, pool_finished;
    fmap_addr_t pool_rd [4];

    addr_stream_if conv_if ();

    // phase is left for debug probes
    layer_sequencer u_seq (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .pix_valid     (pix_valid),
        .pix_ready     (pix_ready),
        .img_wr_addr   (img_wr_addr),
        .conv_go       (conv_go),
        .conv_finished (conv_finished),
        .pool_go       (pool_go),
        .pool_finished (pool_finished),
        .done          (done),
        .phase         ()
    );

    conv_window_addr u_conv (
        .clk      (clk),
        .reset    (reset),
        .go       (conv_go),
        .finished (conv_finished),
        .stream   (conv_if.source)
    );

    pool_window_addr u_pool (
        .clk      (clk),
        .reset    (reset),
        .go       (pool_go),
        .finished (pool_finished),
        .valid    (pool_valid),
        .ready    (pool_ready),
        .rd_addr  (pool_rd),
        .wr_addr  (pool_wr_addr)
    );

    // sink side of the conv stream onto plain ports
    assign conv_if.ready = conv_ready;
    assign conv_valid    = conv_if.valid;
    assign conv_img_addr = conv_if.img_addr;
    assign conv_k_addr   = conv_if.k_addr;
    assign conv_out_addr = conv_if.out_addr;
    assign conv_last_tap = conv_if.last_tap;

    assign pool_rd_addr0 = pool_rd[0];
    assign pool_rd_addr1 = pool_rd[1];
    assign pool_rd_addr2 = pool_rd[2];
    assign pool_rd_addr3 = pool_rd[3];

endmodule

`default_nettype wire

// ==== sim/tb_cnn_addr_ctrl.sv ====
//////////////////////////////////////////////////////////////////////
// One start per run, full layer 1 walk under LFSR-driven ready/valid.
// Checks addresses and flags only; the LFSR seed is fixed.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_cnn_addr_ctrl
    import cnn_dims_pkg::*;
();

    localparam int CONV_ITEMS   = NUM_K * CONV_PIXELS * K_TAPS;
    localparam int POOL_ITEMS   = NUM_K * POOL_PIXELS;
    localparam int DONE_TIMEOUT = 200000;
    localparam int HOLD_CYCLES  = 20;

    logic       clk = 1'b0;
    logic       reset;
    logic       start;
    logic       pix_valid;
    logic       pix_ready;
    img_addr_t  img_wr_addr;
    logic       conv_valid;
    logic       conv_ready;
    img_addr_t  conv_img_addr;
    k_addr_t    conv_k_addr;
    fmap_addr_t conv_out_addr;
    logic       conv_last_tap;
    logic       pool_valid;
    logic       pool_ready;
    fmap_addr_t pool_rd_addr0;
    fmap_addr_t pool_rd_addr1;
    fmap_addr_t pool_rd_addr2;
    fmap_addr_t pool_rd_addr3;
    pool_addr_t pool_wr_addr;
    logic       done;

    logic [31:0] lfsr;
    int          value_errors;
    int          other_errors;
    int          timeout_errors;
    int          load_idx;
    int          conv_idx;
    int          pool_idx;
    fmap_addr_t  prev_out;
    logic        prev_last;
    logic        done_seen;

    cnn_addr_ctrl UUT (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .pix_valid     (pix_valid),
        .pix_ready     (pix_ready),
        .img_wr_addr   (img_wr_addr),
        .conv_valid    (conv_valid),
        .conv_ready    (conv_ready),
        .conv_img_addr (conv_img_addr),
        .conv_k_addr   (conv_k_addr),
        .conv_out_addr (conv_out_addr),
        .conv_last_tap (conv_last_tap),
        .pool_valid    (pool_valid),
        .pool_ready    (pool_ready),
        .pool_rd_addr0 (pool_rd_addr0),
        .pool_rd_addr1 (pool_rd_addr1),
        .pool_rd_addr2 (pool_rd_addr2),
        .pool_rd_addr3 (pool_rd_addr3),
        .pool_wr_addr  (pool_wr_addr),
        .done          (done)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    task automatic take_bit(output logic b);
        b    = lfsr[0];
        lfsr = lfsr_next(lfsr);
    endtask

    // conv order: kernel, row, col, tap with tap = kr*5 + kc
    function automatic img_addr_t ref_conv_img(input int idx);
        int tap, rem, row, col;
        tap = idx % K_TAPS;
        rem = (idx / K_TAPS) % CONV_PIXELS;
        row = rem / CONV_W;
        col = rem % CONV_W;
        return img_addr_t'((row + tap / K_W) * IMG_W + col + tap % K_W);
    endfunction

    function automatic k_addr_t ref_conv_k(input int idx);
        int kern;
        kern = idx / (K_TAPS * CONV_PIXELS);
        return k_addr_t'(kern * K_TAPS + idx % K_TAPS);
    endfunction

    function automatic fmap_addr_t ref_conv_out(input int idx);
        int kern, rem;
        kern = idx / (K_TAPS * CONV_PIXELS);
        rem  = (idx / K_TAPS) % CONV_PIXELS;
        return fmap_addr_t'(kern * CONV_PIXELS + (rem / CONV_W) * CONV_W + rem % CONV_W);
    endfunction

    function automatic logic ref_last_tap(input int idx);
        return (idx % K_TAPS) == (K_TAPS - 1);
    endfunction

    // d selects the window corner: (0,0), (0,1), (1,0), (1,1)
    function automatic fmap_addr_t ref_pool_rd(input int idx, input int d);
        int ch, pr, pc;
        ch = idx / POOL_PIXELS;
        pr = (idx % POOL_PIXELS) / POOL_W;
        pc = (idx % POOL_PIXELS) % POOL_W;
        return fmap_addr_t'(ch * CONV_PIXELS + (2 * pr + d / 2) * CONV_W + 2 * pc + d % 2);
    endfunction

    function automatic pool_addr_t ref_pool_wr(input int idx);
        int ch, rem;
        ch  = idx / POOL_PIXELS;
        rem = idx % POOL_PIXELS;
        return pool_addr_t'(ch * POOL_PIXELS + (rem / POOL_W) * POOL_W + rem % POOL_W);
    endfunction

    task automatic check_img(input string name, input int idx,
                             input img_addr_t got, input img_addr_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %s item %0d: got 0x%h, expected 0x%h", name, idx, got, exp);
        end
    endtask

    task automatic check_k(input string name, input int idx,
                           input k_addr_t got, input k_addr_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %s item %0d: got 0x%h, expected 0x%h", name, idx, got, exp);
        end
    endtask

    task automatic check_fmap(input string name, input int idx,
                              input fmap_addr_t got, input fmap_addr_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %s item %0d: got 0x%h, expected 0x%h", name, idx, got, exp);
        end
    endtask

    task automatic check_pool(input string name, input int idx,
                              input pool_addr_t got, input pool_addr_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %s item %0d: got 0x%h, expected 0x%h", name, idx, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input int idx, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %s item %0d: got 0x%h, expected 0x%h", name, idx, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            other_errors++;
            $display("%s stream moved %0d items but %0d were expected", name, got, exp);
        end
    endtask

    // random valid and ready, one LFSR bit each
    always @(negedge clk) begin
        take_bit(pix_valid);
        take_bit(conv_ready);
        take_bit(pool_ready);
    end

    // transfers are taken on the rising edge, outputs still hold the item
    always @(posedge clk) begin
        if (!reset) begin
            if (pix_valid && pix_ready) begin
                check_img("img_wr_addr", load_idx, img_wr_addr, img_addr_t'(load_idx));
                load_idx++;
            end
            if (conv_valid && conv_ready) begin
                check_img("conv_img_addr", conv_idx, conv_img_addr, ref_conv_img(conv_idx));
                check_k("conv_k_addr", conv_idx, conv_k_addr, ref_conv_k(conv_idx));
                check_fmap("conv_out_addr", conv_idx, conv_out_addr, ref_conv_out(conv_idx));
                check_flag("conv_last_tap", conv_idx, conv_last_tap, ref_last_tap(conv_idx));
                if (conv_idx > 0 && conv_out_addr != prev_out && !prev_last) begin
                    other_errors++;
                    $display("conv_out_addr moved at item %0d without a last tap before it",
                             conv_idx);
                end
                prev_out  = conv_out_addr;
                prev_last = conv_last_tap;
                conv_idx++;
            end
            if (pool_valid && pool_ready) begin
                check_fmap("pool_rd_addr0", pool_idx, pool_rd_addr0, ref_pool_rd(pool_idx, 0));
                check_fmap("pool_rd_addr1", pool_idx, pool_rd_addr1, ref_pool_rd(pool_idx, 1));
                check_fmap("pool_rd_addr2", pool_idx, pool_rd_addr2, ref_pool_rd(pool_idx, 2));
                check_fmap("pool_rd_addr3", pool_idx, pool_rd_addr3, ref_pool_rd(pool_idx, 3));
                check_pool("pool_wr_addr", pool_idx, pool_wr_addr, ref_pool_wr(pool_idx));
                pool_idx++;
            end
            if (done) begin
                if (conv_valid || pool_valid) begin
                    other_errors++;
                    $display("a conv or pool valid is high while done is high");
                end
                if (!done_seen && pool_idx != POOL_ITEMS) begin
                    other_errors++;
                    $display("done rose after only %0d pool transfers", pool_idx);
                end
                done_seen = 1'b1;
            end else if (done_seen) begin
                other_errors++;
                $display("done fell before a new start");
            end
        end
    end

    initial begin
        int cycles;
        reset          = 1'b1;
        start          = 1'b0;
        pix_valid      = 1'b0;
        conv_ready     = 1'b0;
        pool_ready     = 1'b0;
        lfsr           = 32'h73a7;
        value_errors   = 0;
        other_errors   = 0;
        timeout_errors = 0;
        load_idx       = 0;
        conv_idx       = 0;
        pool_idx       = 0;
        prev_out       = '0;
        prev_last      = 1'b0;
        done_seen      = 1'b0;

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        check_flag("pix_ready", 0, pix_ready, 1'b0);
        check_flag("conv_valid", 0, conv_valid, 1'b0);
        check_flag("pool_valid", 0, pool_valid, 1'b0);
        check_flag("done", 0, done, 1'b0);

        start = 1'b1;
        @(negedge clk);
        start = 1'b0;

        cycles = 0;
        while (!done && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            timeout_errors++;
            $display("done did not rise within %0d cycles of start", DONE_TIMEOUT);
        end else begin
            // done must hold with both streams quiet
            repeat (HOLD_CYCLES) @(negedge clk);
        end

        check_count("load", load_idx, IMG_PIXELS);
        check_count("conv", conv_idx, CONV_ITEMS);
        check_count("pool", pool_idx, POOL_ITEMS);

        $display("errors: %0d value, %0d protocol, %0d timeout",
                 value_errors, other_errors, timeout_errors);
        if (value_errors + other_errors + timeout_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/cnn_dims_pkg.sv
rtl/cnn_ctrl_pkg.sv
rtl/addr_stream_if.sv
rtl/conv_window_addr.sv
rtl/pool_window_addr.sv
rtl/layer_sequencer.sv
rtl/cnn_addr_ctrl.sv
sim/tb_cnn_addr_ctrl.sv

// ==== Makefile ====
# Verilator build and run of the layer 1 address controller testbench

SIM := obj_dir/Vtb_cnn_addr_ctrl

.PHONY: all run clean

all: run

$(SIM): tb.f $(wildcard rtl/*.sv) $(wildcard sim/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_cnn_addr_ctrl

run: $(SIM)
	$(SIM) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "SIMULATION FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
